/* all.f */
hw/lspPkg.sv
hw/basicOps.sv
hw/scratchMemory.sv
hw/lspExpand2Fsm.sv
hw/lspExpandPipe.sv
verif/lspExpandChecker.sv
verif/lspExpandTb.sv

/* hw/basicOps.sv */
`timescale 1ns/1ps
`default_nettype none

module basicOps
	import lspPkg::*;
(
	// sub(var1, var2)
	input  wire  signed [15:0] opSubA,
	input  wire  signed [15:0] opSubB,
	// add(var1, var2)
	input  wire  signed [15:0] opAddA,
	input  wire  signed [15:0] opAddB,
	// shr(var1, 1)
	input  wire  signed [15:0] opShr,
	output logic signed [15:0] subResult,
	output logic signed [15:0] addResult,
	output logic signed [15:0] shrResult
);

	////////////////////////////////////////////////////////////
	// Saturation helper
	////////////////////////////////////////////////////////////

	// Clamp a 17-bit result into the 16-bit range
	function automatic logic signed [15:0] saturate(input logic signed [16:0] wide);
		logic signed [15:0] clamped;
		if (wide > 17'(lspMax))
			clamped = lspMax;
		else if (wide < 17'(lspMin))
			clamped = lspMin;
		else
			clamped = wide[15:0];
		return clamped;
	endfunction

	// Full-precision intermediates, one guard bit each
	logic signed [16:0] wideDiff;
	logic signed [16:0] wideSum;

	////////////////////////////////////////////////////////////
	// Operators
	////////////////////////////////////////////////////////////

	// Sign-extend both operands before the difference
	assign wideDiff = 17'(opSubA) - 17'(opSubB);

	// Same for the sum
	assign wideSum = 17'(opAddA) + 17'(opAddB);

	// Saturated 16-bit results
	assign subResult = saturate(wideDiff);
	assign addResult = saturate(wideSum);

	// Arithmetic shift keeps the sign, rounds toward minus infinity
	assign shrResult = opShr >>> 1;

endmodule

`default_nettype wire

/* hw/lspExpand2Fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module lspExpand2Fsm
	import lspPkg::*;
#(
	parameter int addrWidth = lspAddrWidth
)
(
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      start,
	input  wire  signed [15:0]       gap,
	input  wire  [lspWordWidth-1:0]  memIn,
	// Operator results, same cycle
	input  wire  signed [15:0]       subResult,
	input  wire  signed [15:0]       addResult,
	input  wire  signed [15:0]       shrResult,
	// Scratch memory engine port
	output logic [addrWidth-1:0]     engineReadAddr,
	output logic [addrWidth-1:0]     engineWriteAddr,
	output logic [lspWordWidth-1:0]  engineWriteData,
	output logic                     engineWriteEn,
	// Operator operands
	output logic signed [15:0]       opSubA,
	output logic signed [15:0]       opSubB,
	output logic signed [15:0]       opAddA,
	output logic signed [15:0]       opAddB,
	output logic signed [15:0]       opShr,
	output logic                     done
);

	////////////////////////////////////////////////////////////
	// State encoding
	////////////////////////////////////////////////////////////

	localparam logic [3:0] sIdle      = 4'd0;
	// Address of entry j-1, first pair only
	localparam logic [3:0] sReadPrev  = 4'd1;
	// Entry j-1 arrives, address of entry j goes out
	localparam logic [3:0] sLatchPrev = 4'd2;
	// Address of entry j, later pairs
	localparam logic [3:0] sReadCur   = 4'd3;
	localparam logic [3:0] sLoadCur   = 4'd4;
	localparam logic [3:0] sCalcTmp   = 4'd5;
	// Adjusted pair through sub and add
	localparam logic [3:0] sUpdate    = 4'd6;
	localparam logic [3:0] sWritePrev = 4'd7;
	localparam logic [3:0] sWriteCur  = 4'd8;

	// Sign-extend a 16-bit value into a memory word
	function automatic logic [lspWordWidth-1:0] signExtend(input logic signed [15:0] value);
		return {{(lspWordWidth-16){value[15]}}, value};
	endfunction

	logic [3:0] state;
	// Pair index j
	logic [3:0] pairIdx;

	// Pass operands
	logic signed [15:0] gapReg;
	logic signed [15:0] prevVal;
	logic signed [15:0] curVal;
	logic signed [15:0] tmpReg;

	logic lastPair;
	logic tmpPositive;
	logic advance;

	assign lastPair    = (pairIdx == 4'(lspOrder - 1));
	assign tmpPositive = (shrResult > 16'sd0);

	// Pair finished, either nothing to adjust or both words written
	assign advance = (state == sCalcTmp && !tmpPositive) || (state == sWriteCur);

	////////////////////////////////////////////////////////////
	// Read address and operand select
	////////////////////////////////////////////////////////////

	always_comb
	begin
		if (state == sReadPrev)
			engineReadAddr = addrWidth'(lspBufAddr + pairIdx - 1);
		else
			engineReadAddr = addrWidth'(lspBufAddr + pairIdx);
	end

	// tmp = shr(add(sub(prev, cur), gap), 1) by default
	always_comb
	begin
		opSubA = prevVal;
		opSubB = curVal;
		opAddA = subResult;
		opAddB = gapReg;
		opShr  = addResult;
		// Update pass, prev - tmp and cur + tmp
		if (state == sUpdate)
		begin
			opSubB = tmpReg;
			opAddA = curVal;
			opAddB = tmpReg;
		end
	end

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state         <= sIdle;
			pairIdx       <= '0;
			done          <= 1'b0;
			engineWriteEn <= 1'b0;
		end
		else
		begin
			// Strobes
			done          <= 1'b0;
			engineWriteEn <= 1'b0;
			case (state)
				sIdle:
				begin
					// Start only counts here, busy starts drop
					if (start)
					begin
						pairIdx <= 4'(lspHalf);
						state   <= sReadPrev;
					end
				end
				sReadPrev:
					state <= sLatchPrev;
				sLatchPrev:
					state <= sLoadCur;
				sReadCur:
					state <= sLoadCur;
				sLoadCur:
					state <= sCalcTmp;
				sCalcTmp:
				begin
					if (tmpPositive)
						state <= sUpdate;
				end
				sUpdate:
				begin
					// Enable lines up with sWritePrev
					engineWriteEn <= 1'b1;
					state         <= sWritePrev;
				end
				sWritePrev:
				begin
					engineWriteEn <= 1'b1;
					state         <= sWriteCur;
				end
				sWriteCur:
					state <= sWriteCur;
				default:
					state <= sIdle;
			endcase
			// Next pair or end of pass
			if (advance)
			begin
				if (lastPair)
				begin
					state <= sIdle;
					done  <= 1'b1;
				end
				else
				begin
					pairIdx <= pairIdx + 4'd1;
					state   <= sReadCur;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Datapath registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		case (state)
			sIdle:
			begin
				// Gap taken with the start strobe
				if (start)
					gapReg <= gap;
			end
			sLatchPrev:
				prevVal <= memIn[15:0];
			sLoadCur:
				curVal <= memIn[15:0];
			sCalcTmp:
				tmpReg <= shrResult;
			sUpdate:
			begin
				// Entry j-1 goes out first, entry j kept for the second write
				curVal          <= addResult;
				engineWriteAddr <= addrWidth'(lspBufAddr + pairIdx - 1);
				engineWriteData <= signExtend(subResult);
			end
			sWritePrev:
			begin
				engineWriteAddr <= addrWidth'(lspBufAddr + pairIdx);
				engineWriteData <= signExtend(curVal);
			end
			default:
			begin
			end
		endcase
		// Entry j, updated or not, becomes the next entry j-1
		if (advance)
			prevVal <= curVal;
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("lspExpand2Fsm: done high in two consecutive cycles");

	// Registered enable has to stay inside the write window
	assert property (@(posedge clk) disable iff (reset)
		engineWriteEn |-> (state == sWritePrev || state == sWriteCur))
		else $error("lspExpand2Fsm: engine write outside the write states");

endmodule

`default_nettype wire

/* hw/lspExpandPipe.sv */
`timescale 1ns/1ps
`default_nettype none

module lspExpandPipe
	import lspPkg::*;
#(
	parameter int addrWidth = lspAddrWidth
)
(
	input  wire                      clk,
	input  wire                      reset,
	// Host port
	input  wire                      hostSel,
	input  wire  [addrWidth-1:0]     hostReadAddr,
	input  wire  [addrWidth-1:0]     hostWriteAddr,
	input  wire  [lspWordWidth-1:0]  hostWriteData,
	input  wire                      hostWriteEn,
	// Pass control
	input  wire  signed [15:0]       gap,
	input  wire                      start,
	output logic [lspWordWidth-1:0]  memIn,
	output logic                     done
);

	////////////////////////////////////////////////////////////
	// Interconnect
	////////////////////////////////////////////////////////////

	// Engine memory port
	logic [addrWidth-1:0]    engineReadAddr;
	logic [addrWidth-1:0]    engineWriteAddr;
	logic [lspWordWidth-1:0] engineWriteData;
	logic                    engineWriteEn;

	// Operator operands and results
	logic signed [15:0] opSubA;
	logic signed [15:0] opSubB;
	logic signed [15:0] opAddA;
	logic signed [15:0] opAddB;
	logic signed [15:0] opShr;
	logic signed [15:0] subResult;
	logic signed [15:0] addResult;
	logic signed [15:0] shrResult;

	// Vector storage, host loads and reads back here
	scratchMemory #(
		.addrWidth(addrWidth)
	) testMem (
		.clk(clk),
		.hostSel(hostSel),
		.hostReadAddr(hostReadAddr),
		.hostWriteAddr(hostWriteAddr),
		.hostWriteData(hostWriteData),
		.hostWriteEn(hostWriteEn),
		.engineReadAddr(engineReadAddr),
		.engineWriteAddr(engineWriteAddr),
		.engineWriteData(engineWriteData),
		.engineWriteEn(engineWriteEn),
		.memIn(memIn)
	);

	// G.729 basic operators
	basicOps ops (
		.opSubA(opSubA),
		.opSubB(opSubB),
		.opAddA(opAddA),
		.opAddB(opAddB),
		.opShr(opShr),
		.subResult(subResult),
		.addResult(addResult),
		.shrResult(shrResult)
	);

	// Second expansion pass engine
	lspExpand2Fsm #(
		.addrWidth(addrWidth)
	) fsm (
		.clk(clk),
		.reset(reset),
		.start(start),
		.gap(gap),
		.memIn(memIn),
		.subResult(subResult),
		.addResult(addResult),
		.shrResult(shrResult),
		.engineReadAddr(engineReadAddr),
		.engineWriteAddr(engineWriteAddr),
		.engineWriteData(engineWriteData),
		.engineWriteEn(engineWriteEn),
		.opSubA(opSubA),
		.opSubB(opSubB),
		.opAddA(opAddA),
		.opAddB(opAddB),
		.opShr(opShr),
		.done(done)
	);

endmodule

`default_nettype wire

/* hw/lspPkg.sv */
`default_nettype none

package lspPkg;

	////////////////////////////////////////////////////////////
	// Memory layout
	////////////////////////////////////////////////////////////

	// One scratch word, 16-bit values sit sign-extended inside
	localparam int lspWordWidth = 32;

	// Default address width of the scratch memory
	localparam int lspAddrWidth = 11;

	// Word address of entry 0 of the LSP vector
	localparam int lspBufAddr = 160;

	////////////////////////////////////////////////////////////
	// G.729 LSP constants
	////////////////////////////////////////////////////////////

	// Number of LSP coefficients (M in the reference code)
	localparam int lspOrder = 10;

	// First index of the second expansion pass (NC)
	localparam int lspHalf = 5;

	// Saturation limits of the 16-bit basic operators
	localparam logic signed [15:0] lspMax = 16'sh7fff;
	localparam logic signed [15:0] lspMin = 16'sh8000;

endpackage

`default_nettype wire

/* hw/scratchMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module scratchMemory
	import lspPkg::*;
#(
	parameter int addrWidth = lspAddrWidth
)
(
	input  wire                     clk,
	// Host owns both ports while high
	input  wire                     hostSel,
	input  wire [addrWidth-1:0]     hostReadAddr,
	input  wire [addrWidth-1:0]     hostWriteAddr,
	input  wire [lspWordWidth-1:0]  hostWriteData,
	input  wire                     hostWriteEn,
	// Engine side
	input  wire [addrWidth-1:0]     engineReadAddr,
	input  wire [addrWidth-1:0]     engineWriteAddr,
	input  wire [lspWordWidth-1:0]  engineWriteData,
	input  wire                     engineWriteEn,
	// Registered read data, shared by host and engine
	output logic [lspWordWidth-1:0] memIn
);

	// Word array
	logic [lspWordWidth-1:0] mem [2**addrWidth];

	// Selected port signals
	logic [addrWidth-1:0]    readAddr;
	logic [addrWidth-1:0]    writeAddr;
	logic [lspWordWidth-1:0] writeData;
	logic                    writeEn;

	////////////////////////////////////////////////////////////
	// Port select
	////////////////////////////////////////////////////////////

	always_comb
	begin
		if (hostSel)
		begin
			readAddr  = hostReadAddr;
			writeAddr = hostWriteAddr;
			writeData = hostWriteData;
			writeEn   = hostWriteEn;
		end
		else
		begin
			readAddr  = engineReadAddr;
			writeAddr = engineWriteAddr;
			writeData = engineWriteData;
			writeEn   = engineWriteEn;
		end
	end

	// Write on the edge, read data one cycle later
	always_ff @(posedge clk)
	begin
		if (writeEn)
			mem[writeAddr] <= writeData;
		// read returns the old word on a same-address write
		memIn <= mem[readAddr];
	end

	// Engine writes get lost while the host holds the ports
	assert property (@(posedge clk) hostSel |-> !engineWriteEn)
		else $error("scratchMemory: engine write while host owns the memory");

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module lspExpandTb -f all.f -o simLsp \
	&& ./obj_dir/simLsp | tee sim.log
grep -qx "Everything OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* verif/lspExpandChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module lspExpandChecker
	import lspPkg::*;
#(
	parameter int addrWidth = lspAddrWidth
)
(
	input  wire                     clk,
	input  wire                     reset,
	input  wire                     hostSel,
	input  wire [addrWidth-1:0]     hostReadAddr,
	input  wire [addrWidth-1:0]     hostWriteAddr,
	input  wire [lspWordWidth-1:0]  hostWriteData,
	input  wire                     hostWriteEn,
	input  wire signed [15:0]       gap,
	input  wire                     start,
	input  wire [lspWordWidth-1:0]  memIn,
	input  wire                     done,
	input  wire [2:0]               testId,
	output int                      valueErrors,
	output int                      protocolErrors,
	output int                      checkCount,
	output int                      startCount,
	output int                      doneCount
);

	// Shadow of the scratch memory, only host-written words are known
	logic [lspWordWidth-1:0] shadow [2**addrWidth];
	bit                      shadowValid [2**addrWidth];

	// Read pipeline, one cycle like the memory
	bit                      armed;
	logic                    pending;
	logic [addrWidth-1:0]    expectAddr;
	logic [lspWordWidth-1:0] expectWord;
	logic [2:0]              liveTest;

	////////////////////////////////////////////////////////////
	// Reference operators
	////////////////////////////////////////////////////////////

	function automatic logic signed [15:0] clampWord(input int value);
		if (value > int'(lspMax))
			return lspMax;
		if (value < int'(lspMin))
			return lspMin;
		return value[15:0];
	endfunction

	function automatic logic signed [15:0] satSub(input logic signed [15:0] a,
		input logic signed [15:0] b);
		return clampWord(int'(a) - int'(b));
	endfunction

	function automatic logic signed [15:0] satAdd(input logic signed [15:0] a,
		input logic signed [15:0] b);
		return clampWord(int'(a) + int'(b));
	endfunction

	// Floor of v/2
	function automatic logic signed [15:0] halfDown(input logic signed [15:0] v);
		return 16'((int'(v) - (int'(v) & 1)) / 2);
	endfunction

	function automatic logic [lspWordWidth-1:0] entryWord(input logic signed [15:0] v);
		return {{(lspWordWidth-16){v[15]}}, v};
	endfunction

	function automatic logic [addrWidth-1:0] entryAddr(input logic [3:0] idx);
		return addrWidth'(lspBufAddr + int'(idx));
	endfunction

	function automatic string testName(input logic [2:0] id);
		case (id)
			3'd0: return "randomGap10";
			3'd1: return "randomGap5";
			3'd2: return "wideSpacing";
			3'd3: return "saturation";
			3'd4: return "busyStart";
			default: return "unknown";
		endcase
	endfunction

	// Second expansion pass, each step sees the previous step's writes
	task automatic expandModel(input logic signed [15:0] gapVal);
		logic [3:0]         j;
		logic signed [15:0] prev;
		logic signed [15:0] cur;
		logic signed [15:0] tmp;
		for (j = 4'(lspHalf); j < 4'(lspOrder); j++)
		begin
			prev = shadow[entryAddr(j - 4'd1)][15:0];
			cur  = shadow[entryAddr(j)][15:0];
			tmp  = halfDown(satAdd(satSub(prev, cur), gapVal));
			if (tmp > 16'sd0)
			begin
				shadow[entryAddr(j - 4'd1)] = entryWord(satSub(prev, tmp));
				shadow[entryAddr(j)]        = entryWord(satAdd(cur, tmp));
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Input side, sampled on the rising edge
	////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		armed    <= !reset;
		liveTest <= testId;
		if (reset)
		begin
			startCount <= 0;
			pending    <= 1'b0;
		end
		else
		begin
			// Old word comes back on a same-address write
			pending    <= hostSel && shadowValid[hostReadAddr];
			expectAddr <= hostReadAddr;
			expectWord <= shadow[hostReadAddr];
			if (hostSel && hostWriteEn)
			begin
				shadow[hostWriteAddr]      = hostWriteData;
				shadowValid[hostWriteAddr] = 1'b1;
			end
			// Starts while a pass runs are dropped
			if (start && startCount == doneCount)
			begin
				expandModel(gap);
				startCount <= startCount + 1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Output side, compared mid-cycle
	////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (!armed)
		begin
			valueErrors    = 0;
			protocolErrors = 0;
			checkCount     = 0;
			doneCount      = 0;
		end
		else
		begin
			if (pending)
			begin
				checkCount++;
				if (memIn !== expectWord)
				begin
					valueErrors++;
					$display("Fail %s: word %0d expected %h actual %h",
						testName(liveTest), expectAddr, expectWord, memIn);
				end
			end
			// One done per accepted start
			if (done)
			begin
				if (doneCount == startCount)
				begin
					protocolErrors++;
					$display("Done strobe in test %s with no pass running",
						testName(liveTest));
				end
				else
					doneCount++;
			end
		end
	end

endmodule

`default_nettype wire

/* verif/lspExpandTb.sv */
`timescale 1ns/1ps
`default_nettype none

module lspExpandTb
	import lspPkg::*;
();

	////////////////////////////////////////////////////////////
	// Run length
	////////////////////////////////////////////////////////////

	localparam int addrWidth   = lspAddrWidth;
	localparam int nRandom10   = 16;
	localparam int nRandom5    = 16;
	localparam int nWide       = 8;
	localparam int nSaturate   = 12;
	localparam int nBusy       = 6;
	localparam int totalPasses = nRandom10 + nRandom5 + nWide + nSaturate + nBusy;
	// Start to done bound
	localparam int passLimit   = 60;
	// Guard word, 10 entries, guard word
	localparam int imageLen    = lspOrder + 2;

	logic                    clk;
	logic                    reset;
	logic                    hostSel;
	logic [addrWidth-1:0]    hostReadAddr;
	logic [addrWidth-1:0]    hostWriteAddr;
	logic [lspWordWidth-1:0] hostWriteData;
	logic                    hostWriteEn;
	logic signed [15:0]      gap;
	logic                    start;
	logic [lspWordWidth-1:0] memIn;
	logic                    done;
	logic [2:0]              testId;

	int valueErrors;
	int protocolErrors;
	int checkCount;
	int startCount;
	int doneCount;
	int runErrors;

	// Words loaded from lspBufAddr-1 upward
	logic [lspWordWidth-1:0] image [imageLen];

	lspExpandPipe #(
		.addrWidth(addrWidth)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.hostSel(hostSel),
		.hostReadAddr(hostReadAddr),
		.hostWriteAddr(hostWriteAddr),
		.hostWriteData(hostWriteData),
		.hostWriteEn(hostWriteEn),
		.gap(gap),
		.start(start),
		.memIn(memIn),
		.done(done)
	);

	lspExpandChecker #(
		.addrWidth(addrWidth)
	) checker0 (
		.clk(clk),
		.reset(reset),
		.hostSel(hostSel),
		.hostReadAddr(hostReadAddr),
		.hostWriteAddr(hostWriteAddr),
		.hostWriteData(hostWriteData),
		.hostWriteEn(hostWriteEn),
		.gap(gap),
		.start(start),
		.memIn(memIn),
		.done(done),
		.testId(testId),
		.valueErrors(valueErrors),
		.protocolErrors(protocolErrors),
		.checkCount(checkCount),
		.startCount(startCount),
		.doneCount(doneCount)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Watchdog, 200 cycles per pass
	initial
	begin
		repeat (totalPasses * 200 + 20) @(posedge clk);
		$display("Watchdog expired before all passes completed");
		$display("Something failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	function automatic logic [lspWordWidth-1:0] widen(input logic signed [15:0] v);
		return {{(lspWordWidth-16){v[15]}}, v};
	endfunction

	// Values at or a little inside the 16-bit limits
	function automatic logic signed [15:0] nearLimit();
		int pick;
		int offset;
		pick   = int'($urandom() % 5);
		offset = int'($urandom() % 16);
		case (pick)
			0: return 16'(int'(lspMax) - offset);
			1: return 16'(int'(lspMin) + offset);
			2: return lspMax;
			3: return lspMin;
			default: return 16'($urandom());
		endcase
	endfunction

	// Random entries, full 32-bit guard words
	task automatic fillRandom();
		logic [3:0] i;
		for (i = 0; i < 4'(imageLen); i++)
			image[i] = widen(16'($urandom()));
		image[0]                 = $urandom();
		image[4'(imageLen - 1)]  = $urandom();
	endtask

	// Rising vector, every step wider than the gap
	task automatic fillWide(input int gapVal);
		logic [3:0] i;
		int         level;
		fillRandom();
		level = -20000 + int'($urandom() % 5000);
		for (i = 1; i <= 4'(lspOrder); i++)
		begin
			image[i] = widen(16'(level));
			level    = level + gapVal + 1 + int'($urandom() % 1500);
		end
	endtask

	task automatic fillNearLimits();
		logic [3:0] i;
		fillRandom();
		for (i = 1; i <= 4'(lspOrder); i++)
			image[i] = widen(nearLimit());
	endtask

	// Load, start, wait for done, read back; entered and left on a falling edge
	task automatic expandOnce(input logic signed [15:0] passGap, input logic extraStart);
		logic [3:0] i;
		int         cycles;
		hostSel = 1'b1;
		for (i = 0; i < 4'(imageLen); i++)
		begin
			hostWriteAddr = addrWidth'(lspBufAddr - 1 + int'(i));
			hostWriteData = image[i];
			hostWriteEn   = 1'b1;
			@(negedge clk);
		end
		hostWriteEn = 1'b0;
		hostSel     = 1'b0;
		gap         = passGap;
		start       = 1'b1;
		@(negedge clk);
		// Gap only counts at start
		start = 1'b0;
		gap   = 16'($urandom());
		if (extraStart)
		begin
			repeat (3) @(negedge clk);
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
		end
		cycles = 0;
		while (done !== 1'b1 && cycles < passLimit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (done !== 1'b1)
		begin
			runErrors++;
			$display("No done strobe within %0d cycles of start in test %0d", passLimit, testId);
		end
		hostSel = 1'b1;
		for (i = 0; i < 4'(imageLen); i++)
		begin
			hostReadAddr = addrWidth'(lspBufAddr - 1 + int'(i));
			@(negedge clk);
		end
		@(negedge clk);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int n;
		int totalErrors;
		void'($urandom(15));
		reset         = 1'b1;
		hostSel       = 1'b0;
		hostReadAddr  = '0;
		hostWriteAddr = '0;
		hostWriteData = '0;
		hostWriteEn   = 1'b0;
		gap           = 16'sd0;
		start         = 1'b0;
		testId        = 3'd0;
		runErrors     = 0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		repeat (nRandom10)
		begin
			fillRandom();
			expandOnce(16'sd10, 1'b0);
		end
		testId = 3'd1;
		repeat (nRandom5)
		begin
			fillRandom();
			expandOnce(16'sd5, 1'b0);
		end
		// Already spaced, nothing should move
		testId = 3'd2;
		repeat (nWide)
		begin
			n = (($urandom() % 2) != 0) ? 10 : 5;
			fillWide(n);
			expandOnce(16'(n), 1'b0);
		end
		testId = 3'd3;
		repeat (nSaturate)
		begin
			fillNearLimits();
			expandOnce(16'sd10, 1'b0);
		end
		// Second start lands mid-pass
		testId = 3'd4;
		repeat (nBusy)
		begin
			fillRandom();
			expandOnce(16'sd10, 1'b1);
		end
		repeat (4) @(negedge clk);
		if (startCount != totalPasses || doneCount != totalPasses)
		begin
			runErrors++;
			$display("Accepted %0d starts and saw %0d done strobes for %0d passes",
				startCount, doneCount, totalPasses);
		end
		if (checkCount < totalPasses * imageLen)
		begin
			runErrors++;
			$display("Only %0d readback words were compared", checkCount);
		end
		totalErrors = valueErrors + protocolErrors + runErrors;
		$display("Error counts: value %0d, done %0d, run %0d, words compared %0d",
			valueErrors, protocolErrors, runErrors, checkCount);
		if (totalErrors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire
